// ==== rtl/l1b_addr_pkg.sv ====
// address and data geometry of one l1b bank
package l1b_addr_pkg;

  // single-port rams behind one bank
  localparam int LB_RAM_NUM = 8;

  // chip select picks one ram out of the bank
  localparam int LB_CS_ADDR_WID = $clog2(LB_RAM_NUM);

  // quad words inside one ram, 256 by default
  localparam int LB_RAM_QW_ADDR_WID = 8;

  // flat lsu address over the whole bank
  // ram address bits plus chip select bits
  localparam int LSU_BANK_QW_ADDR_WID = LB_RAM_QW_ADDR_WID + LB_CS_ADDR_WID;

  // one quad word of payload
  localparam int QW_DATA_WID = 64;

endpackage

// ==== rtl/l1b_cfg_pkg.sv ====
// software view of the bank configuration registers
package l1b_cfg_pkg;

  // register index, room for eight slots
  localparam int CFG_IDX_WID = 3;

  // write data bus from software
  localparam int CFG_DATA_WID = 16;

  // ram base offset
  localparam logic [CFG_IDX_WID-1:0] CFG_BASE = 3'd0;
  // quad words used per ram
  localparam logic [CFG_IDX_WID-1:0] CFG_RANGE = 3'd1;
  // section thresholds, largest first
  localparam logic [CFG_IDX_WID-1:0] CFG_SEC_2ND = 3'd2;
  localparam logic [CFG_IDX_WID-1:0] CFG_SEC_4TH = 3'd3;
  localparam logic [CFG_IDX_WID-1:0] CFG_SEC_8TH = 3'd4;

  // indices 5 to 7 are unused, writes there are dropped

endpackage

// ==== rtl/l1b_cfg_regs.sv ====
`timescale 1ns/1ps

module l1b_cfg_regs #(
  parameter int  RAM_QW_ADDR_WID  = l1b_addr_pkg::LB_RAM_QW_ADDR_WID,
  localparam int BANK_QW_ADDR_WID = RAM_QW_ADDR_WID + l1b_addr_pkg::LB_CS_ADDR_WID
) (
  input  logic                                clk,
  input  logic                                arst_n,
  // software write port
  input  logic                                cfg_we,
  input  logic [l1b_cfg_pkg::CFG_IDX_WID-1:0] cfg_idx,
  input  logic [l1b_cfg_pkg::CFG_DATA_WID-1:0] cfg_wdata,
  // decode settings
  output logic [RAM_QW_ADDR_WID-1:0]          base_addr,
  output logic [RAM_QW_ADDR_WID:0]            ram_range,
  output logic [BANK_QW_ADDR_WID-1:0]         sec_one_2nd,
  output logic [BANK_QW_ADDR_WID-2:0]         sec_one_4th,
  output logic [BANK_QW_ADDR_WID-3:0]         sec_one_8th
);

  import l1b_cfg_pkg::*;

  // one register per index, strobe written
  // new value shows on the outputs from the next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      base_addr   <= '0;
      ram_range   <= '0;
      sec_one_2nd <= '0;
      sec_one_4th <= '0;
      sec_one_8th <= '0;
    end else if (cfg_we) begin
      // wdata cut down to each register width
      case (cfg_idx)
        CFG_BASE: begin
          base_addr <= cfg_wdata[RAM_QW_ADDR_WID-1:0];
        end
        CFG_RANGE: begin
          // one extra bit so a full ram of quad words fits
          ram_range <= cfg_wdata[RAM_QW_ADDR_WID:0];
        end
        CFG_SEC_2ND: begin
          sec_one_2nd <= cfg_wdata[BANK_QW_ADDR_WID-1:0];
        end
        CFG_SEC_4TH: begin
          sec_one_4th <= cfg_wdata[BANK_QW_ADDR_WID-2:0];
        end
        CFG_SEC_8TH: begin
          sec_one_8th <= cfg_wdata[BANK_QW_ADDR_WID-3:0];
        end
        default: begin
          // unused slot, nothing stored
        end
      endcase
    end
  end

  // software must only target the five defined slots
  a_cfg_idx_legal: assert property (
    @(posedge clk) disable iff (!arst_n)
    cfg_we |-> (cfg_idx <= CFG_SEC_8TH)
  ) else $error("config write to unused index %0d", cfg_idx);

endmodule

// ==== rtl/l1b_cache_qw_addr_dichotomie_comp.sv ====
`timescale 1ns/1ps

module l1b_cache_qw_addr_dichotomie_comp #(
  parameter int  RAM_QW_ADDR_WID  = l1b_addr_pkg::LB_RAM_QW_ADDR_WID,
  localparam int BANK_QW_ADDR_WID = RAM_QW_ADDR_WID + l1b_addr_pkg::LB_CS_ADDR_WID
) (
  // flat quad word address over the bank
  input  logic [BANK_QW_ADDR_WID-1:0]            lsu_addr,
  input  logic [RAM_QW_ADDR_WID-1:0]             base_addr,
  input  logic [RAM_QW_ADDR_WID:0]               ram_range,
  // section thresholds
  input  logic [BANK_QW_ADDR_WID-1:0]            sec_one_2nd,
  input  logic [BANK_QW_ADDR_WID-2:0]            sec_one_4th,
  input  logic [BANK_QW_ADDR_WID-3:0]            sec_one_8th,
  // decoded ram and address inside it
  output logic [l1b_addr_pkg::LB_CS_ADDR_WID-1:0] ram_cs,
  output logic [RAM_QW_ADDR_WID-1:0]             ram_addr
);

  import l1b_addr_pkg::*;

  // remainders after each halving step
  logic [BANK_QW_ADDR_WID-1:0] rem_2nd;
  logic [BANK_QW_ADDR_WID-1:0] rem_4th;
  // start of the selected ram in the flat space
  logic [BANK_QW_ADDR_WID-1:0] cs_span;
  // offset left inside the selected ram
  logic [BANK_QW_ADDR_WID-1:0] ram_offset;

  // binary search, largest section first
  always_comb begin
    // top bit, upper half of the bank
    ram_cs[LB_CS_ADDR_WID-1] = (lsu_addr >= sec_one_2nd);
    rem_2nd = ram_cs[LB_CS_ADDR_WID-1] ? (lsu_addr - sec_one_2nd) : lsu_addr;

    // middle bit, quarter inside that half
    ram_cs[LB_CS_ADDR_WID-2] = (rem_2nd >= {1'b0, sec_one_4th});
    rem_4th = ram_cs[LB_CS_ADDR_WID-2] ? (rem_2nd - {1'b0, sec_one_4th}) : rem_2nd;

    // low bit, eighth inside that quarter
    ram_cs[LB_CS_ADDR_WID-3] = (rem_4th >= {2'b0, sec_one_8th});
  end

  // rams are laid out back to back, each range quad words long
  always_comb begin
    cs_span    = BANK_QW_ADDR_WID'(ram_cs) * BANK_QW_ADDR_WID'(ram_range);
    ram_offset = lsu_addr - cs_span;
    // wraps at ram width
    ram_addr   = base_addr + ram_offset[RAM_QW_ADDR_WID-1:0];
  end

endmodule

// ==== rtl/l1b_ram_bank.sv ====
`timescale 1ns/1ps

module l1b_ram_bank #(
  parameter int RAM_QW_ADDR_WID = l1b_addr_pkg::LB_RAM_QW_ADDR_WID
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  // access strobes from the lsu
  input  logic                                   lsu_we,
  input  logic                                   lsu_re,
  // decoded location
  input  logic [l1b_addr_pkg::LB_CS_ADDR_WID-1:0] ram_cs,
  input  logic [RAM_QW_ADDR_WID-1:0]             ram_addr,
  input  logic [l1b_addr_pkg::QW_DATA_WID-1:0]   lsu_wdata,
  // read return, one cycle after lsu_re
  output logic                                   rd_valid,
  output logic [l1b_addr_pkg::QW_DATA_WID-1:0]   rd_data
);

  import l1b_addr_pkg::*;

  localparam int RAM_DEPTH = 2 ** RAM_QW_ADDR_WID;

  // eight single-port quad word rams, first index is chip select
  logic [QW_DATA_WID-1:0] ram_mem [LB_RAM_NUM][RAM_DEPTH];

  // write on the strobe edge
  // read captured into rd_data on the same kind of edge
  always_ff @(posedge clk) begin
    if (lsu_we) begin
      ram_mem[ram_cs][ram_addr] <= lsu_wdata;
    end
    if (lsu_re) begin
      rd_data <= ram_mem[ram_cs][ram_addr];
    end
  end

  // valid pulse lines up with the captured word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= lsu_re;
    end
  end

  // single port, so never read and write in one cycle
  a_no_rw_same_cycle: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(lsu_we && lsu_re)
  ) else $error("lsu_we and lsu_re high together");

  // fixed one cycle read latency, no stall
  a_rd_valid_after_re: assert property (
    @(posedge clk) disable iff (!arst_n)
    lsu_re |=> rd_valid
  ) else $error("rd_valid missing one cycle after lsu_re");

endmodule

// ==== rtl/l1b_bank_top.sv ====
`timescale 1ns/1ps

module l1b_bank_top #(
  parameter int  RAM_QW_ADDR_WID  = l1b_addr_pkg::LB_RAM_QW_ADDR_WID,
  localparam int BANK_QW_ADDR_WID = RAM_QW_ADDR_WID + l1b_addr_pkg::LB_CS_ADDR_WID
) (
  input  logic                                   clk,
  input  logic                                   arst_n,
  // configuration writes
  input  logic                                   cfg_we,
  input  logic [l1b_cfg_pkg::CFG_IDX_WID-1:0]    cfg_idx,
  input  logic [l1b_cfg_pkg::CFG_DATA_WID-1:0]   cfg_wdata,
  // lsu access
  input  logic                                   lsu_we,
  input  logic                                   lsu_re,
  input  logic [BANK_QW_ADDR_WID-1:0]            lsu_addr,
  input  logic [l1b_addr_pkg::QW_DATA_WID-1:0]   lsu_wdata,
  output logic                                   rd_valid,
  output logic [l1b_addr_pkg::QW_DATA_WID-1:0]   rd_data,
  // decode result, brought out for observation
  output logic [l1b_addr_pkg::LB_CS_ADDR_WID-1:0] ram_cs,
  output logic [RAM_QW_ADDR_WID-1:0]             ram_addr
);

  // config register outputs into the decoder
  logic [RAM_QW_ADDR_WID-1:0]  base_addr;
  logic [RAM_QW_ADDR_WID:0]    ram_range;
  logic [BANK_QW_ADDR_WID-1:0] sec_one_2nd;
  logic [BANK_QW_ADDR_WID-2:0] sec_one_4th;
  logic [BANK_QW_ADDR_WID-3:0] sec_one_8th;

  l1b_cfg_regs #(
    .RAM_QW_ADDR_WID (RAM_QW_ADDR_WID)
  ) l1b_cfg_regs_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg_we      (cfg_we),
    .cfg_idx     (cfg_idx),
    .cfg_wdata   (cfg_wdata),
    .base_addr   (base_addr),
    .ram_range   (ram_range),
    .sec_one_2nd (sec_one_2nd),
    .sec_one_4th (sec_one_4th),
    .sec_one_8th (sec_one_8th)
  );

  // same cycle decode, no clock
  l1b_cache_qw_addr_dichotomie_comp #(
    .RAM_QW_ADDR_WID (RAM_QW_ADDR_WID)
  ) l1b_cache_qw_addr_dichotomie_comp_i (
    .lsu_addr    (lsu_addr),
    .base_addr   (base_addr),
    .ram_range   (ram_range),
    .sec_one_2nd (sec_one_2nd),
    .sec_one_4th (sec_one_4th),
    .sec_one_8th (sec_one_8th),
    .ram_cs      (ram_cs),
    .ram_addr    (ram_addr)
  );

  l1b_ram_bank #(
    .RAM_QW_ADDR_WID (RAM_QW_ADDR_WID)
  ) l1b_ram_bank_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .lsu_we    (lsu_we),
    .lsu_re    (lsu_re),
    .ram_cs    (ram_cs),
    .ram_addr  (ram_addr),
    .lsu_wdata (lsu_wdata),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

endmodule

// ==== verification/tb_l1b_bank.sv ====
`timescale 1ns/1ps

module tb_l1b_bank;

  import l1b_addr_pkg::*;
  import l1b_cfg_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int CS_W       = LB_CS_ADDR_WID;
  localparam int RAM_W      = LB_RAM_QW_ADDR_WID;
  localparam int BANK_W     = LSU_BANK_QW_ADDR_WID;
  localparam int LOC_W      = CS_W + RAM_W;

  // test lengths
  localparam int N_DECODE_A = 200;
  localparam int N_DECODE_B = 100;
  localparam int N_WR       = 100;
  localparam int N_BURST    = 50;
  // reads take two cycles each with the idle gap, plus config and drain slack
  localparam int TEST_CYCLES    = N_DECODE_A + N_DECODE_B + 3 * N_WR + N_BURST + 50;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  logic                    clk;
  logic                    arst_n;
  logic                    cfg_we;
  logic [CFG_IDX_WID-1:0]  cfg_idx;
  logic [CFG_DATA_WID-1:0] cfg_wdata;
  logic                    lsu_we;
  logic                    lsu_re;
  logic [BANK_W-1:0]       lsu_addr;
  logic [QW_DATA_WID-1:0]  lsu_wdata;
  logic                    rd_valid;
  logic [QW_DATA_WID-1:0]  rd_data;
  logic [CS_W-1:0]         ram_cs;
  logic [RAM_W-1:0]        ram_addr;

  // model of what software has written
  int cfg_base  = 0;
  int cfg_range = 0;
  int cfg_sec2  = 0;
  int cfg_sec4  = 0;
  int cfg_sec8  = 0;

  int unsigned lcg_state = 97;
  int          cycle_cnt = 0;
  logic        re_seen;

  // expected contents per ram and word
  logic [QW_DATA_WID-1:0] sb [LB_RAM_NUM][2 ** RAM_W];
  // read results still in flight, oldest first
  logic [QW_DATA_WID-1:0] exp_q [$];
  // addresses that hold known data
  int wr_addrs [$];

  l1b_bank_top #(
    .RAM_QW_ADDR_WID (LB_RAM_QW_ADDR_WID)
  ) l1b_bank_top_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .cfg_we    (cfg_we),
    .cfg_idx   (cfg_idx),
    .cfg_wdata (cfg_wdata),
    .lsu_we    (lsu_we),
    .lsu_re    (lsu_re),
    .lsu_addr  (lsu_addr),
    .lsu_wdata (lsu_wdata),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .ram_cs    (ram_cs),
    .ram_addr  (ram_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // low lcg bits cycle fast, take the upper ones
  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  // search from the largest section down, then place inside the chosen ram
  function automatic logic [LOC_W-1:0] ref_decode(input int addr);
    int rem;
    int cs;
    int ra;
    cs  = 0;
    rem = addr;
    if (rem >= cfg_sec2) begin
      cs  = cs + 4;
      rem = rem - cfg_sec2;
    end
    if (rem >= cfg_sec4) begin
      cs  = cs + 2;
      rem = rem - cfg_sec4;
    end
    if (rem >= cfg_sec8) begin
      cs = cs + 1;
    end
    // wraps inside the ram
    ra = (cfg_base + addr - cs * cfg_range) & ((1 << RAM_W) - 1);
    return {CS_W'(cs), RAM_W'(ra)};
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR @%0t: %s, got %0h expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  // decode outputs against the model for the address now on the bus
  task automatic compare_decode(input string what);
    logic [LOC_W-1:0] loc;
    loc = ref_decode(int'(lsu_addr));
    check_equal(ram_cs, loc[LOC_W-1:RAM_W], {what, " ram_cs"});
    check_equal(ram_addr, loc[RAM_W-1:0], {what, " ram_addr"});
  endtask

  task automatic check_decode(input int addr);
    @(negedge clk);
    lsu_addr = BANK_W'(addr);
    #1;
    compare_decode("decode");
  endtask

  // old setting holds until the write edge, new one right after it
  task automatic write_cfg(input logic [CFG_IDX_WID-1:0] idx, input int value);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_idx   = idx;
    cfg_wdata = CFG_DATA_WID'(value);
    #1;
    compare_decode("before config edge");
    @(negedge clk);
    cfg_we = 1'b0;
    case (idx)
      CFG_BASE:    cfg_base  = value;
      CFG_RANGE:   cfg_range = value;
      CFG_SEC_2ND: cfg_sec2  = value;
      CFG_SEC_4TH: cfg_sec4  = value;
      CFG_SEC_8TH: cfg_sec8  = value;
      default:     cfg_base  = cfg_base;
    endcase
    #1;
    compare_decode("after config edge");
  endtask

  task automatic write_word(input int addr, input logic [QW_DATA_WID-1:0] data);
    logic [LOC_W-1:0] loc;
    @(negedge clk);
    lsu_we    = 1'b1;
    lsu_re    = 1'b0;
    lsu_addr  = BANK_W'(addr);
    lsu_wdata = data;
    loc = ref_decode(addr);
    sb[loc[LOC_W-1:RAM_W]][loc[RAM_W-1:0]] = data;
  endtask

  task automatic read_word(input int addr);
    logic [LOC_W-1:0] loc;
    @(negedge clk);
    lsu_we   = 1'b0;
    lsu_re   = 1'b1;
    lsu_addr = BANK_W'(addr);
    loc = ref_decode(addr);
    exp_q.push_back(sb[loc[LOC_W-1:RAM_W]][loc[RAM_W-1:0]]);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    lsu_we = 1'b0;
    lsu_re = 1'b0;
  endtask

  // lsu_re as seen by the bank on each edge
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      re_seen <= 1'b0;
    end else begin
      re_seen <= lsu_re;
    end
  end

  // result side, sampled mid cycle
  always @(negedge clk) begin : compare_results
    logic [QW_DATA_WID-1:0] exp_data;
    if (arst_n) begin
      check_equal(rd_valid, re_seen, "rd_valid one cycle after lsu_re");
      if (rd_valid) begin
        if (exp_q.size() == 0) begin
          $display("read result arrived with no read outstanding");
          $display("sim failed");
          $fatal(1);
        end
        exp_data = exp_q.pop_front();
        check_equal(rd_data, exp_data, "rd_data");
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $fatal(1);
    end
  end

  initial begin
    arst_n    = 1'b0;
    cfg_we    = 1'b0;
    cfg_idx   = '0;
    cfg_wdata = '0;
    lsu_we    = 1'b0;
    lsu_re    = 1'b0;
    lsu_addr  = '0;
    lsu_wdata = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // quiet bank after reset
    repeat (4) idle_cycle();
    check_equal(rd_valid, 1'b0, "rd_valid after reset");

    // even layout, 32 words per ram
    write_cfg(CFG_RANGE, 32);
    write_cfg(CFG_BASE, 0);
    write_cfg(CFG_SEC_2ND, 128);
    write_cfg(CFG_SEC_4TH, 64);
    write_cfg(CFG_SEC_8TH, 32);
    for (int i = 0; i < N_DECODE_A; i++) begin
      check_decode(rand_below(256));
    end

    // offset base and uneven sections
    write_cfg(CFG_BASE, 17);
    write_cfg(CFG_RANGE, 37);
    write_cfg(CFG_SEC_2ND, 150);
    write_cfg(CFG_SEC_4TH, 70);
    write_cfg(CFG_SEC_8TH, 33);
    for (int i = 0; i < N_DECODE_B; i++) begin
      check_decode(rand_below(320));
    end

    // fill, then read back with a gap so each valid pulse stands alone
    for (int i = 0; i < N_WR; i++) begin
      wr_addrs.push_back(rand_below(320));
      write_word(wr_addrs[i], {lcg_next(), lcg_next()});
    end
    idle_cycle();
    for (int i = 0; i < N_WR; i++) begin
      read_word(wr_addrs[i]);
      idle_cycle();
    end

    // back to back, one result per cycle
    for (int i = 0; i < N_BURST; i++) begin
      read_word(wr_addrs[rand_below(wr_addrs.size())]);
    end
    repeat (3) idle_cycle();

    check_equal(exp_q.size(), 0, "reads left without a result");
    $display("sim passed");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/l1b_addr_pkg.sv
rtl/l1b_cfg_pkg.sv
rtl/l1b_cfg_regs.sv
rtl/l1b_cache_qw_addr_dichotomie_comp.sv
rtl/l1b_ram_bank.sv
rtl/l1b_bank_top.sv
verification/tb_l1b_bank.sv

// ==== Bender.yml ====
package:
  name: l1b_bank

sources:
  # packages first, then the bank RTL
  - files:
      - rtl/l1b_addr_pkg.sv
      - rtl/l1b_cfg_pkg.sv
      - rtl/l1b_cfg_regs.sv
      - rtl/l1b_cache_qw_addr_dichotomie_comp.sv
      - rtl/l1b_ram_bank.sv
      - rtl/l1b_bank_top.sv

  # testbench
  - target: test
    files:
      - verification/tb_l1b_bank.sv
